// ==== src/knn_config.svh ====
`ifndef KNN_CONFIG_SVH
`define KNN_CONFIG_SVH

////////////////////////////////////////
// data sizes
`define KNN_ELEM_W      11                      // bits per patch element
`define KNN_DIST_W      11                      // saturating distance
`define KNN_PATCH_SIZE  5

////////////////////////////////////////
// memory geometry
`define KNN_LEAF_SIZE   8                       // patches per leaf
`define KNN_NUM_LEAVES  64
`define KNN_K           4                       // results returned
`define KNN_LEAF_AW     $clog2(`KNN_NUM_LEAVES)
`define KNN_SLOT_W      $clog2(`KNN_LEAF_SIZE)

`endif

// ==== src/knn_data_pkg.sv ====
`include "knn_config.svh"

package knn_data_pkg;

    ////////////////////////////////////////
    // patch data
    typedef logic signed [`KNN_ELEM_W-1:0] elem_t;
    typedef elem_t [`KNN_PATCH_SIZE-1:0]   patch_t;

    ////////////////////////////////////////
    // search results
    typedef logic [`KNN_DIST_W-1:0]  dist_t;      // saturates at all ones
    typedef logic [`KNN_LEAF_AW-1:0] leaf_addr_t;

    // leaf number in the upper bits, slot in the lower bits
    typedef logic [`KNN_LEAF_AW+`KNN_SLOT_W-1:0] cand_idx_t;

    typedef dist_t     [`KNN_LEAF_SIZE-1:0] slot_dist_t;
    typedef cand_idx_t [`KNN_LEAF_SIZE-1:0] slot_idx_t;

    typedef dist_t     [`KNN_K-1:0] best_dist_t;  // entry 0 is the nearest
    typedef cand_idx_t [`KNN_K-1:0] best_idx_t;

endpackage

// ==== src/knn_ctrl_pkg.sv ====
package knn_ctrl_pkg;

    // leaf scan sequencing
    typedef enum logic {
        IDLE,
        SCAN
    } scan_state_t;

endpackage

// ==== src/leaf_mem.sv ====
`timescale 1ns/1ps
`include "knn_config.svh"

module leaf_mem (
    input  logic                                         clk,
    input  logic                                         wr_en,
    input  knn_data_pkg::leaf_addr_t                     wr_leaf,
    input  logic [`KNN_SLOT_W-1:0]                       wr_slot,
    input  knn_data_pkg::patch_t                         wr_patch,
    input  logic                                         rd_en,
    input  knn_data_pkg::leaf_addr_t                     rd_leaf,
    output knn_data_pkg::patch_t [`KNN_LEAF_SIZE-1:0]    leaf_data
);

    import knn_data_pkg::*;

    patch_t mem [`KNN_NUM_LEAVES][`KNN_LEAF_SIZE];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_leaf][wr_slot] <= wr_patch;          // one patch per cycle
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int s = 0; s < `KNN_LEAF_SIZE; s++) begin
                leaf_data[s] <= mem[rd_leaf][s];        // whole leaf at once
            end
        end
    end

    ////////////////////////////////////////
    // checks

    // the leaf being scanned must not change under the read
    a_no_rw_same_leaf : assert property (@(posedge clk)
        !(wr_en && rd_en && (wr_leaf == rd_leaf)))
        else $error("leaf_mem: write and read of leaf %0d in one cycle", rd_leaf);

endmodule

// ==== src/search_ctrl.sv ====
`timescale 1ns/1ps
`include "knn_config.svh"

module search_ctrl (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    output logic                        rd_en,
    output logic                        rd_first,
    output logic                        rd_last,
    output knn_data_pkg::leaf_addr_t    rd_leaf
);

    import knn_data_pkg::*;
    import knn_ctrl_pkg::*;

    localparam leaf_addr_t LAST_LEAF = leaf_addr_t'(`KNN_NUM_LEAVES - 1);

    scan_state_t state;
    leaf_addr_t  leaf_cnt;

    ////////////////////////////////////////
    // scan FSM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            leaf_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    leaf_cnt <= '0;
                    if (start) begin
                        state <= SCAN;
                    end
                end
                SCAN: begin
                    leaf_cnt <= leaf_cnt + 1'b1;        // wraps to 0 after the last leaf
                    if (leaf_cnt == LAST_LEAF) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign rd_en    = (state == SCAN);                  // one leaf read per cycle
    assign rd_leaf  = leaf_cnt;
    assign rd_first = rd_en && (leaf_cnt == '0);
    assign rd_last  = rd_en && (leaf_cnt == LAST_LEAF);

    ////////////////////////////////////////
    // checks

    // the scan stops right after the last leaf
    a_stop_after_last : assert property (@(posedge clk) disable iff (!rst_n)
        rd_last |=> (state == IDLE) && !rd_en)
        else $error("search_ctrl: read issued after the last leaf");

    // an accepted start opens the scan at leaf 0
    a_start_first : assert property (@(posedge clk) disable iff (!rst_n)
        (state == IDLE) && start |=> rd_first)
        else $error("search_ctrl: scan did not begin at leaf 0");

endmodule

// ==== src/l2_dist_kernel.sv ====
`timescale 1ns/1ps
`include "knn_config.svh"

module l2_dist_kernel (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        rd_en,
    input  logic                                        rd_first,
    input  logic                                        rd_last,
    input  knn_data_pkg::leaf_addr_t                    rd_leaf,
    input  knn_data_pkg::patch_t [`KNN_LEAF_SIZE-1:0]   leaf_data,
    input  knn_data_pkg::patch_t                        query_patch,
    output logic                                        dist_valid,
    output logic                                        dist_first,
    output logic                                        dist_last,
    output knn_data_pkg::slot_dist_t                    slot_dist,
    output knn_data_pkg::slot_idx_t                     slot_idx
);

    import knn_data_pkg::*;

    localparam int DIFF_W = `KNN_ELEM_W + 1;
    localparam int SQ_W   = 2 * DIFF_W;
    localparam int SUM_W  = SQ_W + $clog2(`KNN_PATCH_SIZE);
    localparam dist_t DIST_MAX = '1;

    logic       t_valid, t_first, t_last;               // tags aligned to leaf_data
    leaf_addr_t t_leaf;
    logic       s1_valid, s1_first, s1_last;
    leaf_addr_t s1_leaf;

    logic signed [DIFF_W-1:0] diff  [`KNN_LEAF_SIZE][`KNN_PATCH_SIZE];
    logic [SQ_W-1:0]          sq    [`KNN_LEAF_SIZE][`KNN_PATCH_SIZE];
    logic [SQ_W-1:0]          s1_sq [`KNN_LEAF_SIZE][`KNN_PATCH_SIZE];
    logic [SUM_W-1:0]         sum   [`KNN_LEAF_SIZE];

    always_comb begin
        for (int s = 0; s < `KNN_LEAF_SIZE; s++) begin
            for (int e = 0; e < `KNN_PATCH_SIZE; e++) begin
                diff[s][e] = leaf_data[s][e] - query_patch[e];
                sq[s][e]   = diff[s][e] * diff[s][e];
            end
        end
    end

    always_comb begin
        for (int s = 0; s < `KNN_LEAF_SIZE; s++) begin
            sum[s] = '0;
            for (int e = 0; e < `KNN_PATCH_SIZE; e++) begin
                sum[s] = sum[s] + SUM_W'(s1_sq[s][e]);
            end
        end
    end

    ////////////////////////////////////////
    // tag pipeline
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            {t_valid, t_first, t_last}          <= '0;
            {s1_valid, s1_first, s1_last}       <= '0;
            {dist_valid, dist_first, dist_last} <= '0;
        end else begin
            {t_valid, t_first, t_last}          <= {rd_en, rd_first, rd_last};
            {s1_valid, s1_first, s1_last}       <= {t_valid, t_first, t_last};
            {dist_valid, dist_first, dist_last} <= {s1_valid, s1_first, s1_last};
        end
    end

    ////////////////////////////////////////
    // data pipeline
    always_ff @(posedge clk) begin
        t_leaf  <= rd_leaf;
        s1_leaf <= t_leaf;
        s1_sq   <= sq;                                  // stage one
        for (int s = 0; s < `KNN_LEAF_SIZE; s++) begin
            slot_dist[s] <= (sum[s] > SUM_W'(DIST_MAX)) ? DIST_MAX
                                                        : sum[s][`KNN_DIST_W-1:0];
            slot_idx[s]  <= {s1_leaf, `KNN_SLOT_W'(s)}; // leaf * LEAF_SIZE + slot
        end
    end

endmodule

// ==== src/running_min.sv ====
`timescale 1ns/1ps
`include "knn_config.svh"

module running_min (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        dist_valid,
    input  logic                        dist_first,
    input  logic                        dist_last,
    input  knn_data_pkg::slot_dist_t    slot_dist,
    input  knn_data_pkg::slot_idx_t     slot_idx,
    output logic                        min_valid,
    output knn_data_pkg::slot_dist_t    min_dist,
    output knn_data_pkg::slot_idx_t     min_idx
);

    import knn_data_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            min_valid <= 1'b0;
        end else begin
            min_valid <= dist_valid && dist_last;       // last leaf folded in
        end
    end

    ////////////////////////////////////////
    // per-slot minimum
    always_ff @(posedge clk) begin
        if (dist_valid) begin
            for (int s = 0; s < `KNN_LEAF_SIZE; s++) begin
                // strict compare so a tie keeps the earlier leaf
                if (dist_first || (slot_dist[s] < min_dist[s])) begin
                    min_dist[s] <= slot_dist[s];
                    min_idx[s]  <= slot_idx[s];
                end
            end
        end
    end

    ////////////////////////////////////////
    // checks

    a_tags_need_valid : assert property (@(posedge clk) disable iff (!rst_n)
        (dist_first || dist_last) |-> dist_valid)
        else $error("running_min: leaf tag without dist_valid");

endmodule

// ==== src/bitonic_top_k.sv ====
`timescale 1ns/1ps
`include "knn_config.svh"

module bitonic_top_k (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        min_valid,
    input  knn_data_pkg::slot_dist_t    min_dist,
    input  knn_data_pkg::slot_idx_t     min_idx,
    output logic                        done,
    output knn_data_pkg::best_dist_t    best_dist,
    output knn_data_pkg::best_idx_t     best_idx
);

    import knn_data_pkg::*;

    logic       s1_valid, s2_valid;
    slot_dist_t s1_dist, s2_dist;
    slot_idx_t  s1_idx, s2_idx;
    slot_dist_t n1_dist, n2_dist, n3_dist;
    slot_idx_t  n1_idx, n2_idx, n3_idx;

    // one compare-exchange layer of the network, block size k and span j
    function automatic void cmp_layer(input int k, input int j,
                                      inout slot_dist_t d, inout slot_idx_t x);
        int        l;
        logic      i_gt_l;
        dist_t     td;
        cand_idx_t tx;
        for (int i = 0; i < `KNN_LEAF_SIZE; i++) begin
            l = i ^ j;
            if (l > i) begin
                i_gt_l = (d[i] > d[l]) || ((d[i] == d[l]) && (x[i] > x[l]));
                if (((i & k) == 0) ? i_gt_l : !i_gt_l) begin
                    td   = d[i];
                    tx   = x[i];
                    d[i] = d[l];
                    x[i] = x[l];
                    d[l] = td;
                    x[l] = tx;
                end
            end
        end
    endfunction

    ////////////////////////////////////////
    // network, two layers per stage
    always_comb begin
        n1_dist = min_dist;
        n1_idx  = min_idx;
        cmp_layer(2, 1, n1_dist, n1_idx);
        cmp_layer(4, 2, n1_dist, n1_idx);
        n2_dist = s1_dist;
        n2_idx  = s1_idx;
        cmp_layer(4, 1, n2_dist, n2_idx);
        cmp_layer(8, 4, n2_dist, n2_idx);
        n3_dist = s2_dist;
        n3_idx  = s2_idx;
        cmp_layer(8, 2, n3_dist, n3_idx);
        cmp_layer(8, 1, n3_dist, n3_idx);               // fully ascending now
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            done      <= 1'b0;
            best_dist <= '0;
            best_idx  <= '0;
        end else begin
            s1_valid <= min_valid;
            s2_valid <= s1_valid;
            done     <= s2_valid;
            if (s2_valid) begin
                best_dist <= n3_dist[`KNN_K-1:0];       // held until the next search
                best_idx  <= n3_idx[`KNN_K-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        s1_dist <= n1_dist;
        s1_idx  <= n1_idx;
        s2_dist <= n2_dist;
        s2_idx  <= n2_idx;
    end

    ////////////////////////////////////////
    // checks
    for (genvar i = 0; i < `KNN_K - 1; i++) begin : g_order_chk
        a_sorted : assert property (@(posedge clk) disable iff (!rst_n)
            done |-> (best_dist[i] <= best_dist[i+1]))
            else $error("bitonic_top_k: result %0d out of order", i);
    end

endmodule

// ==== src/knn_search_top.sv ====
`timescale 1ns/1ps
`include "knn_config.svh"

module knn_search_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic                        wr_en,
    input  knn_data_pkg::leaf_addr_t    wr_leaf,
    input  logic [`KNN_SLOT_W-1:0]      wr_slot,
    input  knn_data_pkg::patch_t        wr_patch,
    input  knn_data_pkg::patch_t        query_patch,
    output logic                        done,
    output knn_data_pkg::best_dist_t    best_dist,
    output knn_data_pkg::best_idx_t     best_idx
);

    import knn_data_pkg::*;

    logic                          rd_en, rd_first, rd_last;
    leaf_addr_t                    rd_leaf;
    patch_t [`KNN_LEAF_SIZE-1:0]   leaf_data;
    logic                          dist_valid, dist_first, dist_last;
    slot_dist_t                    slot_dist;
    slot_idx_t                     slot_idx;
    logic                          min_valid;
    slot_dist_t                    min_dist;
    slot_idx_t                     min_idx;

    ////////////////////////////////////////
    // producer
    search_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .rd_en      (rd_en),
        .rd_first   (rd_first),
        .rd_last    (rd_last),
        .rd_leaf    (rd_leaf)
    );

    leaf_mem u_mem (
        .clk        (clk),
        .wr_en      (wr_en),
        .wr_leaf    (wr_leaf),
        .wr_slot    (wr_slot),
        .wr_patch   (wr_patch),
        .rd_en      (rd_en),
        .rd_leaf    (rd_leaf),
        .leaf_data  (leaf_data)
    );

    l2_dist_kernel u_kernel (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_en       (rd_en),
        .rd_first    (rd_first),
        .rd_last     (rd_last),
        .rd_leaf     (rd_leaf),
        .leaf_data   (leaf_data),
        .query_patch (query_patch),
        .dist_valid  (dist_valid),
        .dist_first  (dist_first),
        .dist_last   (dist_last),
        .slot_dist   (slot_dist),
        .slot_idx    (slot_idx)
    );

    ////////////////////////////////////////
    // buffer and consumer
    running_min u_min (
        .clk        (clk),
        .rst_n      (rst_n),
        .dist_valid (dist_valid),
        .dist_first (dist_first),
        .dist_last  (dist_last),
        .slot_dist  (slot_dist),
        .slot_idx   (slot_idx),
        .min_valid  (min_valid),
        .min_dist   (min_dist),
        .min_idx    (min_idx)
    );

    bitonic_top_k u_sort (
        .clk        (clk),
        .rst_n      (rst_n),
        .min_valid  (min_valid),
        .min_dist   (min_dist),
        .min_idx    (min_idx),
        .done       (done),
        .best_dist  (best_dist),
        .best_idx   (best_idx)
    );

endmodule

// ==== tests/tb_knn_search.sv ====
`timescale 1ns/1ps
`include "knn_config.svh"

module tb_knn_search;

    import knn_data_pkg::*;

    localparam int LATENCY    = `KNN_NUM_LEAVES + 7;                // start edge to done edge
    localparam int CANDS      = `KNN_NUM_LEAVES * `KNN_LEAF_SIZE;
    localparam int DIST_MAX   = (1 << `KNN_DIST_W) - 1;
    localparam int SEARCH_CYC = LATENCY + 20;
    localparam int MAX_CYCLES = 8 + 10 + 3 * (CANDS + 1) + 6 * (SEARCH_CYC + 10) + 500;

    logic       clk;
    logic       rst_n;
    logic       start;
    logic       wr_en;
    leaf_addr_t wr_leaf;
    logic [`KNN_SLOT_W-1:0] wr_slot;
    patch_t     wr_patch;
    patch_t     query_patch;
    logic       done;
    best_dist_t best_dist;
    best_idx_t  best_idx;

    int          shadow [`KNN_NUM_LEAVES][`KNN_LEAF_SIZE][`KNN_PATCH_SIZE];
    int          query_vals [`KNN_PATCH_SIZE];
    best_dist_t  exp_dist;
    best_idx_t   exp_idx;
    logic        started, accepted_start;
    string       test_name;
    int          err_cnt, test_cnt, done_cnt, cycle_cnt;
    logic [31:0] rng_state;

    always #20 clk = ~clk;

    knn_search_top u_dut (.*);

    ////////////////////////////////////////
    // checks
    a_idle_after_reset : assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> !done && (best_dist == '0) && (best_idx == '0))
        else begin
            err_cnt++;
            $display("error %s: expected done 0 and zero results, actual done %b dist %h idx %h",
                     test_name, done, best_dist, best_idx);
        end

    a_result_dist : assert property (@(posedge clk) disable iff (!rst_n)
        done |-> (best_dist == exp_dist))
        else begin
            err_cnt++;
            $display("error %s: best_dist expected %h actual %h", test_name, exp_dist, best_dist);
        end

    a_result_idx : assert property (@(posedge clk) disable iff (!rst_n)
        done |-> (best_idx == exp_idx))
        else begin
            err_cnt++;
            $display("error %s: best_idx expected %h actual %h", test_name, exp_idx, best_idx);
        end

    a_latency : assert property (@(posedge clk) disable iff (!rst_n)
        accepted_start |-> ##LATENCY done)
        else begin
            err_cnt++;
            $display("%s: done missing %0d cycles after the start", test_name, LATENCY);
        end

    a_no_stray_done : assert property (@(posedge clk) disable iff (!rst_n)
        done |-> $past(accepted_start, LATENCY))
        else begin
            err_cnt++;
            $display("%s: done without an accepted start %0d cycles before", test_name, LATENCY);
        end

    a_done_pulse : assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else begin
            err_cnt++;
            $display("%s: done held high for more than one cycle", test_name);
        end

    always @(negedge clk) begin
        if (rst_n && done) done_cnt++;                 // one count per done pulse
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run did not end within %0d cycles", MAX_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////
    // stimulus and reference model
    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // mode 0 random -8..7, 1 constant, 2 random +-1000
    function automatic int gen_elem(input int mode);
        logic [31:0] r;
        r = xorshift();
        if (mode == 1) return 3;
        if (mode == 2) return r[0] ? 1000 : -1000;
        return int'(r[3:0]) - 8;
    endfunction

    task automatic write_patch(input int leaf, input int slot, input int vals[`KNN_PATCH_SIZE]);
        @(posedge clk);
        #2;
        wr_en   = 1'b1;
        wr_leaf = leaf[`KNN_LEAF_AW-1:0];
        wr_slot = slot[`KNN_SLOT_W-1:0];
        for (int e = 0; e < `KNN_PATCH_SIZE; e++) begin
            wr_patch[e] = elem_t'(vals[e]);
            shadow[leaf][slot][e] = vals[e];
        end
    endtask

    task automatic end_writes();
        @(posedge clk);
        #2;
        wr_en = 1'b0;
    endtask

    task automatic load_memory(input int mode);
        int vals [`KNN_PATCH_SIZE];
        for (int l = 0; l < `KNN_NUM_LEAVES; l++) begin
            for (int s = 0; s < `KNN_LEAF_SIZE; s++) begin
                for (int e = 0; e < `KNN_PATCH_SIZE; e++) vals[e] = gen_elem(mode);
                write_patch(l, s, vals);
            end
        end
        end_writes();
    endtask

    task automatic set_query(input logic zero);
        @(posedge clk);
        #2;
        for (int e = 0; e < `KNN_PATCH_SIZE; e++) begin
            query_vals[e]  = zero ? 0 : gen_elem(0);
            query_patch[e] = elem_t'(query_vals[e]);
        end
    endtask

    // each slot keeps its nearest leaf, the earliest leaf on a tie
    function automatic void compute_expected();
        int win_d [`KNN_LEAF_SIZE];
        int win_i [`KNN_LEAF_SIZE];
        int sum, diff, d, key, best, prev;
        for (int s = 0; s < `KNN_LEAF_SIZE; s++) begin
            win_d[s] = DIST_MAX + 1;
            win_i[s] = 0;
            for (int l = 0; l < `KNN_NUM_LEAVES; l++) begin
                sum = 0;
                for (int e = 0; e < `KNN_PATCH_SIZE; e++) begin
                    diff = shadow[l][s][e] - query_vals[e];
                    sum  = sum + diff * diff;
                end
                d = (sum > DIST_MAX) ? DIST_MAX : sum;
                if (d < win_d[s]) begin
                    win_d[s] = d;
                    win_i[s] = l * `KNN_LEAF_SIZE + s;
                end
            end
        end
        // key orders by distance first, candidate index second
        prev = -1;
        for (int k = 0; k < `KNN_K; k++) begin
            best = (DIST_MAX + 1) * CANDS;
            for (int s = 0; s < `KNN_LEAF_SIZE; s++) begin
                key = win_d[s] * CANDS + win_i[s];
                if ((key > prev) && (key < best)) begin
                    best = key;
                end
            end
            exp_dist[k] = dist_t'(best / CANDS);
            exp_idx[k]  = cand_idx_t'(best % CANDS);
            prev = best;
        end
    endfunction

    task automatic run_search(input logic extra_start);
        int waited;
        int cnt0;
        compute_expected();
        cnt0 = done_cnt;
        @(posedge clk);
        #2;
        {start, accepted_start, started} = 3'b111;
        @(posedge clk);
        #2;
        {start, accepted_start} = 2'b00;
        waited = 1;
        while (!done && waited < SEARCH_CYC) begin
            @(posedge clk);
            #2;
            waited++;
            start = extra_start && (waited == 10);     // lands mid scan
        end
        if (!done) begin
            err_cnt++;
            $display("%s: no done within %0d cycles of the start", test_name, SEARCH_CYC);
        end
        repeat (16) @(posedge clk);                    // past a done the extra start could cause
        #2;
        assert (done_cnt == cnt0 + 1) else begin
            err_cnt++;
            $display("error %s: done pulses expected 1 actual %0d", test_name, done_cnt - cnt0);
        end
    endtask

    task automatic finish_test(input int err0);
        test_cnt++;
        if (err_cnt == err0) $display("test %s: ok", test_name);
        else $display("test %s: %0d errors", test_name, err_cnt - err0);
    endtask

    ////////////////////////////////////////
    // test sequence
    initial begin
        int err0;
        clk = 1'b0;
        rst_n = 1'b0;
        start = 1'b0;
        wr_en = 1'b0;
        wr_leaf = '0;
        wr_slot = '0;
        wr_patch = '0;
        query_patch = '0;
        {started, accepted_start} = 2'b00;
        {err_cnt, test_cnt, done_cnt, cycle_cnt} = '0;
        exp_dist = '0;
        exp_idx = '0;
        rng_state = 32'd60;
        test_name = "reset_idle";
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;

        err0 = err_cnt;
        repeat (10) @(posedge clk);
        finish_test(err0);

        test_name = "random_search";
        err0 = err_cnt;
        load_memory(0);
        set_query(1'b0);
        run_search(1'b0);
        finish_test(err0);

        test_name = "all_ties";                        // same distance everywhere
        err0 = err_cnt;
        load_memory(1);
        set_query(1'b0);
        run_search(1'b0);
        finish_test(err0);

        test_name = "saturation";
        err0 = err_cnt;
        load_memory(2);
        set_query(1'b1);
        run_search(1'b0);
        finish_test(err0);

        test_name = "rewrite_match";                   // candidate 301 equals the query
        err0 = err_cnt;
        set_query(1'b0);
        write_patch(37, 5, query_vals);
        end_writes();
        run_search(1'b0);
        finish_test(err0);

        test_name = "ignored_start";
        err0 = err_cnt;
        run_search(1'b1);
        finish_test(err0);

        $display("tests %0d, errors %0d", test_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+src
src/knn_data_pkg.sv
src/knn_ctrl_pkg.sv
src/leaf_mem.sv
src/search_ctrl.sv
src/l2_dist_kernel.sv
src/running_min.sv
src/bitonic_top_k.sv
src/knn_search_top.sv
tests/tb_knn_search.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the KNN search testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_knn_search -o sim_knn
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/sim_knn > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" sim.log; then
    exit 1
fi
exit 0
